// File: sources.f
+incdir+logic
+incdir+tb
logic/tx_bd_pkg.sv
logic/bd_fetch.sv
logic/rd_cmd_gen.sv
logic/bd_store.sv
logic/rsp_dispatch.sv
logic/tx_bd_top.sv
tb/tb_tx_bd.sv

// File: Makefile
# Verilator build and run of the tx bd engine testbench
TOP := tb_tx_bd
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_tx_bd_tasks.svh
// directed tests and expected-value model included inside the testbench module
// uses the module's queues and its step, send and check tasks
`ifndef TB_TX_BD_TASKS_SVH
`define TB_TX_BD_TASKS_SVH

    // --------------------
    // model
    // unused restored bits carry noise so the decode must ignore them
    function automatic logic [`TX_BD_QWORD_W-1:0] queue_word(input tx_bd_pkg::bd_desc_t d);
        logic [`TX_BD_CMD_W-1:0] lo;
        lo = {22'($urandom), d.thread_id, d.opcode, 8'($urandom), d.acc_type, d.ve_info,
              d.len, d.des_addr, d.src_addr};
        return {$urandom, tx_bd_pkg::bswap_128x2(lo)};
    endfunction

    task automatic add_expected_cmds(input tx_bd_pkg::bd_desc_t d,
                                     input logic [`TX_BD_SN_W-1:0] sn);
        tx_bd_pkg::rd_cmd_t c;
        logic [31:0]        bytes;
        int                 n;
        bytes = (d.opcode == tx_bd_pkg::op_read) ? 32'd0 : d.len;
        n = (bytes == 0) ? 1 : int'((bytes + `TX_BD_CHUNK_BYTES - 1) / `TX_BD_CHUNK_BYTES);
        for (int k = 0; k < n; k++) begin
            c          = '0;
            c.sod      = (k == 0);
            c.eod      = (k == n - 1);
            c.rd_len   = (k == n - 1) ? 13'(bytes - 32'(k) * `TX_BD_CHUNK_BYTES) : 13'd4096;
            c.opcode   = d.opcode;
            c.sn       = sn;
            c.acc_type = d.acc_type;
            c.ve_info  = d.ve_info;
            c.src_addr = d.src_addr + 64'(k) * 64'(`TX_BD_CHUNK_BYTES);
            exp_cmds.push_back(c);
        end
    endtask

    task automatic push_desc(input tx_bd_pkg::bd_op_e op, input logic [31:0] len);
        tx_bd_pkg::bd_desc_t d;
        d.thread_id = 8'($urandom);
        d.opcode    = op;
        d.acc_type  = 8'($urandom);
        d.ve_info   = {16'($urandom), $urandom};
        d.len       = len;
        d.des_addr  = {$urandom, $urandom};
        d.src_addr  = {$urandom, $urandom};
        stored[next_sn] = d;
        add_expected_cmds(d, next_sn);
        next_sn++;
        bd_queue.push_back(queue_word(d));
    endtask

    // --------------------
    // tests
    function automatic logic outputs_idle();
        return !bd_fifo_rd && !rd_cmd_wr && !kernel_bd_wen && !rx_bd_wen && (bd_wdata == '0);
    endfunction

    task automatic reset_state();
        repeat (16) begin
            @(negedge clk_sys);
            assert (outputs_idle()) else fail_now("outputs active during reset");
        end
        step();
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk_sys);
            assert (outputs_idle()) else fail_now("outputs active just after reset");
        end
        step();
    endtask

    task automatic short_write();
        push_desc(tx_bd_pkg::op_write, 32'd100);
        check_cmds();
    endtask

    task automatic long_split();
        push_desc(tx_bd_pkg::op_proc, 32'd10000);
        check_cmds();
        push_desc(tx_bd_pkg::op_read, 32'd3000);
        check_cmds();
    endtask

    // sink goes full after two commands of a six command split
    task automatic cmd_backpressure();
        int hold;
        hold = 5 + int'($urandom % 26);
        push_desc(tx_bd_pkg::op_proc, 32'd5 * 32'd4096 + 32'd300);
        push_desc(tx_bd_pkg::op_write, 32'd8192);
        while (got_cmds.size() < 2) begin
            step();
        end
        rd_cmd_full = 1'b1;
        repeat (hold) begin
            step();
        end
        rd_cmd_full = 1'b0;
        check_cmds();
    endtask

    task automatic rsp_routing();
        logic [`TX_BD_SN_W-1:0] base;
        base = next_sn;
        push_desc(tx_bd_pkg::op_proc, 32'd64);
        push_desc(tx_bd_pkg::op_read, 32'd200);
        push_desc(tx_bd_pkg::op_write, 32'd5000);
        push_desc(tx_bd_pkg::op_proc_alt, 32'd0);
        check_cmds();
        send_rsp(base + 9'd2);
        send_rsp(base);
        send_rsp(base + 9'd3);
        send_rsp(base + 9'd1);
        check_outs();
    endtask

    task automatic out_backpressure();
        logic [`TX_BD_SN_W-1:0] base;
        base = next_sn;
        push_desc(tx_bd_pkg::op_write, 32'd32);
        push_desc(tx_bd_pkg::op_proc, 32'd4096);
        push_desc(tx_bd_pkg::op_read, 32'd10);
        check_cmds();
        kernel_afull = 1'b1;
        send_rsp(base + 9'd1);
        send_rsp(base);
        send_rsp(base + 9'd2);
        repeat (20) begin
            step();
        end
        assert (got_outs.size() == 0) else fail_now("output written while kernel_afull high");
        kernel_afull = 1'b0;
        check_outs();
    endtask

`endif

// File: tb/tb_tx_bd.sv
// directed tests that keep one descriptor in command generation at a time
// responses are only sent for sequence numbers whose commands were already seen
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module tb_tx_bd;

    // longest test sequence stays far below this
    localparam int max_cycles = 20000;

    logic                      clk_sys = 1'b0;
    logic                      rst;
    logic                      bd_fifo_rd;
    logic [`TX_BD_QWORD_W-1:0] bd_fifo_rdata;
    logic                      bd_fifo_empty;
    logic                      rd_cmd_wr;
    logic [`TX_BD_CMD_W-1:0]   rd_cmd_wdata;
    logic                      rd_cmd_full;
    logic                      rsp_wr;
    logic [`TX_BD_SN_W-1:0]    rsp_sn;
    logic                      kernel_afull;
    logic                      rx_afull;
    logic                      kernel_bd_wen;
    logic                      rx_bd_wen;
    logic [`TX_BD_OUT_W-1:0]   bd_wdata;

    logic [`TX_BD_QWORD_W-1:0] bd_queue [$];
    tx_bd_pkg::rd_cmd_t        exp_cmds [$];
    tx_bd_pkg::rd_cmd_t        got_cmds [$];
    tx_bd_pkg::bd_desc_t       exp_outs [$];
    tx_bd_pkg::bd_desc_t       got_outs [$];
    logic                      got_rx [$];
    tx_bd_pkg::bd_desc_t       stored [`TX_BD_DEPTH];
    logic [`TX_BD_SN_W-1:0]    next_sn;
    int                        pops = 0;
    int                        eods = 0;
    int                        cycles = 0;

    always #50 clk_sys = ~clk_sys;

    tx_bd_top UUT (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bd_fifo_rd    (bd_fifo_rd),
        .bd_fifo_rdata (bd_fifo_rdata),
        .bd_fifo_empty (bd_fifo_empty),
        .rd_cmd_wr     (rd_cmd_wr),
        .rd_cmd_wdata  (rd_cmd_wdata),
        .rd_cmd_full   (rd_cmd_full),
        .rsp_wr        (rsp_wr),
        .rsp_sn        (rsp_sn),
        .kernel_afull  (kernel_afull),
        .rx_afull      (rx_afull),
        .kernel_bd_wen (kernel_bd_wen),
        .rx_bd_wen     (rx_bd_wen),
        .bd_wdata      (bd_wdata)
    );

    task automatic fail_now(input string msg);
        $display("ERR %0d ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    // --------------------
    // the front word of the show-ahead queue leaves after a pop was seen
    initial begin
        int popped;
        popped        = 0;
        bd_fifo_empty = 1'b1;
        bd_fifo_rdata = '0;
        forever begin
            step();
            if (pops > popped && bd_queue.size() > 0) begin
                bd_queue.delete(0);
                popped++;
            end
            bd_fifo_empty = (bd_queue.size() == 0);
            bd_fifo_rdata = bd_fifo_empty ? '0 : bd_queue[0];
        end
    end

    // --------------------
    // monitors sample mid-cycle
    always @(negedge clk_sys) begin
        tx_bd_pkg::rd_cmd_t cmd;
        tx_bd_pkg::bd_out_t ow;
        if (bd_fifo_rd) begin
            assert (pops == eods) else fail_now("descriptor popped before previous eod");
            pops++;
        end
        if (rd_cmd_wr) begin
            assert (!rd_cmd_full) else fail_now("command written while sink full");
            cmd = tx_bd_pkg::rd_cmd_t'(tx_bd_pkg::bswap_128x2(rd_cmd_wdata));
            got_cmds.push_back(cmd);
            if (cmd.eod) begin
                eods++;
            end
        end
        if (kernel_bd_wen || rx_bd_wen) begin
            assert (!(kernel_bd_wen && rx_bd_wen)) else fail_now("both output strobes high");
            ow = tx_bd_pkg::bd_out_t'(tx_bd_pkg::bswap_512(bd_wdata));
            assert (ow.pad == '0) else fail_now($sformatf("output pad not zero: %h", ow.pad));
            got_outs.push_back(ow.desc);
            got_rx.push_back(rx_bd_wen);
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // one response per cycle with output expected in push order
    task automatic send_rsp(input logic [`TX_BD_SN_W-1:0] sn);
        rsp_wr = 1'b1;
        rsp_sn = sn;
        exp_outs.push_back(stored[sn]);
        step();
        rsp_wr = 1'b0;
    endtask

    task automatic check_cmds();
        tx_bd_pkg::rd_cmd_t e;
        tx_bd_pkg::rd_cmd_t g;
        while (exp_cmds.size() > 0) begin
            while (got_cmds.size() == 0) begin
                step();
            end
            e = exp_cmds.pop_front();
            g = got_cmds.pop_front();
            assert (g == e) else fail_now($sformatf("command %h, expected %h", g, e));
        end
        repeat (8) begin
            step();
        end
        assert (got_cmds.size() == 0) else fail_now("unexpected extra command");
    endtask

    task automatic check_outs();
        tx_bd_pkg::bd_desc_t e;
        tx_bd_pkg::bd_desc_t g;
        logic                rx;
        while (exp_outs.size() > 0) begin
            while (got_outs.size() == 0) begin
                step();
            end
            e  = exp_outs.pop_front();
            g  = got_outs.pop_front();
            rx = got_rx.pop_front();
            assert (g == e) else fail_now($sformatf("output %h, expected %h", g, e));
            assert (rx == (e.opcode == tx_bd_pkg::op_read || e.opcode == tx_bd_pkg::op_write))
                else fail_now($sformatf("opcode %0d on wrong output path", e.opcode));
        end
        repeat (8) begin
            step();
        end
        assert (got_outs.size() == 0) else fail_now("unexpected extra output");
    endtask

`include "tb_tx_bd_tasks.svh"

    initial begin
        rst          = 1'b1;
        rd_cmd_full  = 1'b0;
        rsp_wr       = 1'b0;
        rsp_sn       = '0;
        kernel_afull = 1'b0;
        rx_afull     = 1'b0;
        next_sn      = '0;
        void'($urandom(32'hf2d0d7fa));
        reset_state();
        short_write();
        long_split();
        cmd_backpressure();
        rsp_routing();
        out_backpressure();
        if (got_cmds.size() == 0 && got_outs.size() == 0 && exp_outs.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("unchecked commands or outputs left at the end of the run");
            $display("RESULT: FAIL");
            $fatal(1, "stopped with unchecked traffic");
        end
    end

endmodule

// File: logic/tx_bd_top.sv
// tx buffer-descriptor engine
// responses must only carry sn values whose descriptor was popped
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module tx_bd_top (
    input  logic                      clk_sys,
    input  logic                      rst,
    output logic                      bd_fifo_rd,
    input  logic [`TX_BD_QWORD_W-1:0] bd_fifo_rdata,
    input  logic                      bd_fifo_empty,
    output logic                      rd_cmd_wr,
    output logic [`TX_BD_CMD_W-1:0]   rd_cmd_wdata,
    input  logic                      rd_cmd_full,
    input  logic                      rsp_wr,
    input  logic [`TX_BD_SN_W-1:0]    rsp_sn,
    input  logic                      kernel_afull,
    input  logic                      rx_afull,
    output logic                      kernel_bd_wen,
    output logic                      rx_bd_wen,
    output logic [`TX_BD_OUT_W-1:0]   bd_wdata
);

    logic                   desc_valid;
    tx_bd_pkg::bd_desc_t    desc;
    logic [`TX_BD_SN_W-1:0] desc_sn;
    logic                   cmd_done;
    logic [`TX_BD_SN_W-1:0] rd_sn;
    tx_bd_pkg::bd_desc_t    rd_desc;
    logic                   rsp_pop;
    logic                   rsp_afull;

    bd_fetch u_bd_fetch (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bd_fifo_rd    (bd_fifo_rd),
        .bd_fifo_rdata (bd_fifo_rdata),
        .bd_fifo_empty (bd_fifo_empty),
        .rd_cmd_full   (rd_cmd_full),
        .rsp_afull     (rsp_afull),
        .rsp_pop       (rsp_pop),
        .cmd_done      (cmd_done),
        .desc_valid    (desc_valid),
        .desc          (desc),
        .desc_sn       (desc_sn)
    );

    rd_cmd_gen u_rd_cmd_gen (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .desc_valid   (desc_valid),
        .desc         (desc),
        .desc_sn      (desc_sn),
        .rd_cmd_full  (rd_cmd_full),
        .rd_cmd_wr    (rd_cmd_wr),
        .rd_cmd_wdata (rd_cmd_wdata),
        .cmd_done     (cmd_done)
    );

    bd_store u_bd_store (
        .clk_sys (clk_sys),
        .wr      (desc_valid),
        .wr_sn   (desc_sn),
        .wr_desc (desc),
        .rd_sn   (rd_sn),
        .rd_desc (rd_desc)
    );

    rsp_dispatch u_rsp_dispatch (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .rsp_wr        (rsp_wr),
        .rsp_sn        (rsp_sn),
        .kernel_afull  (kernel_afull),
        .rx_afull      (rx_afull),
        .rd_sn         (rd_sn),
        .rd_desc       (rd_desc),
        .rsp_pop       (rsp_pop),
        .rsp_afull     (rsp_afull),
        .kernel_bd_wen (kernel_bd_wen),
        .rx_bd_wen     (rx_bd_wen),
        .bd_wdata      (bd_wdata)
    );

endmodule

// File: logic/rsp_dispatch.sv
// response FIFO, descriptor lookup and output routing
// rsp_wr is dropped when the FIFO is full
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module rsp_dispatch (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    rsp_wr,
    input  logic [`TX_BD_SN_W-1:0]  rsp_sn,
    input  logic                    kernel_afull,
    input  logic                    rx_afull,
    output logic [`TX_BD_SN_W-1:0]  rd_sn,
    input  tx_bd_pkg::bd_desc_t     rd_desc,
    output logic                    rsp_pop,
    output logic                    rsp_afull,
    output logic                    kernel_bd_wen,
    output logic                    rx_bd_wen,
    output logic [`TX_BD_OUT_W-1:0] bd_wdata
);

    logic [`TX_BD_SN_W-1:0] fifo_mem [`TX_BD_DEPTH];
    logic [`TX_BD_SN_W:0]   wr_ptr;
    logic [`TX_BD_SN_W:0]   rd_ptr;
    logic [`TX_BD_SN_W:0]   fill;
    logic                   empty;
    logic                   full;
    logic                   push;
    logic                   pop_d1;
    logic                   is_rx;
    tx_bd_pkg::bd_out_t     out_word;

    // --------------------
    // show-ahead sn FIFO
    assign fill      = wr_ptr - rd_ptr;
    assign empty     = (fill == '0);
    assign full      = (fill == `TX_BD_DEPTH);
    assign rsp_afull = (fill >= `TX_BD_RSP_AFULL);
    assign push      = rsp_wr && !full;
    assign rd_sn     = fifo_mem[rd_ptr[`TX_BD_SN_W-1:0]];

    always_ff @(posedge clk_sys) begin
        if (push) begin
            fifo_mem[wr_ptr[`TX_BD_SN_W-1:0]] <= rsp_sn;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rsp_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // at most every other cycle
    assign rsp_pop = !empty && !kernel_afull && !rx_afull && !pop_d1;

    // --------------------
    // output stage
    assign is_rx = (rd_desc.opcode == tx_bd_pkg::op_read)
                   || (rd_desc.opcode == tx_bd_pkg::op_write);

    always_comb begin
        out_word      = '0;
        out_word.desc = rd_desc;
    end

    // pop, then RAM read, then strobe
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            pop_d1        <= 1'b0;
            kernel_bd_wen <= 1'b0;
            rx_bd_wen     <= 1'b0;
            bd_wdata      <= '0;
        end else begin
            pop_d1        <= rsp_pop;
            kernel_bd_wen <= pop_d1 && !is_rx;
            rx_bd_wen     <= pop_d1 && is_rx;
            if (pop_d1) begin
                bd_wdata <= tx_bd_pkg::bswap_512(out_word);
            end
        end
    end

endmodule

// File: logic/bd_store.sv
// descriptor RAM indexed by sequence number
// read data appears one cycle after rd_sn
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module bd_store (
    input  logic                   clk_sys,
    input  logic                   wr,
    input  logic [`TX_BD_SN_W-1:0] wr_sn,
    input  tx_bd_pkg::bd_desc_t    wr_desc,
    input  logic [`TX_BD_SN_W-1:0] rd_sn,
    output tx_bd_pkg::bd_desc_t    rd_desc
);

    tx_bd_pkg::bd_desc_t mem [`TX_BD_DEPTH];

    // --------------------
    // write port
    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[wr_sn] <= wr_desc;
        end
    end

    // --------------------
    // registered read port
    always_ff @(posedge clk_sys) begin
        rd_desc <= mem[rd_sn];
    end

endmodule

// File: logic/rd_cmd_gen.sv
// splits a descriptor into read commands of up to 4 KiB each
// expects a new desc_valid only after cmd_done of the previous one
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module rd_cmd_gen (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    desc_valid,
    input  tx_bd_pkg::bd_desc_t     desc,
    input  logic [`TX_BD_SN_W-1:0]  desc_sn,
    input  logic                    rd_cmd_full,
    output logic                    rd_cmd_wr,
    output logic [`TX_BD_CMD_W-1:0] rd_cmd_wdata,
    output logic                    cmd_done
);

    localparam logic [`TX_BD_CHUNK_SHIFT:0] chunk_len = `TX_BD_CHUNK_BYTES;

    logic                        pend;
    logic                        first;
    logic                        wr_d;
    logic [31:0]                 rem_len;
    logic [63:0]                 addr;
    logic [`TX_BD_SN_W-1:0]      sn;
    tx_bd_pkg::bd_op_e           opcode;
    logic [7:0]                  acc_type;
    logic [47:0]                 ve_info;
    logic                        last;
    logic [`TX_BD_CHUNK_SHIFT:0] cur_len;
    tx_bd_pkg::rd_cmd_t          cmd;

    // --------------------
    // chunk selection
    assign last    = (rem_len <= `TX_BD_CHUNK_BYTES);
    assign cur_len = last ? rem_len[`TX_BD_CHUNK_SHIFT:0] : chunk_len;

    // one idle cycle between writes, and none while the sink is full
    assign rd_cmd_wr = pend && !wr_d && !rd_cmd_full;
    assign cmd_done  = rd_cmd_wr && last;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            pend    <= 1'b0;
            first   <= 1'b0;
            wr_d    <= 1'b0;
            rem_len <= '0;
        end else begin
            wr_d <= rd_cmd_wr;
            if (desc_valid) begin
                pend    <= 1'b1;
                first   <= 1'b1;
                // a read needs no source data
                rem_len <= (desc.opcode == tx_bd_pkg::op_read) ? 32'd0 : desc.len;
            end else if (rd_cmd_wr) begin
                first   <= 1'b0;
                rem_len <= rem_len - 32'(cur_len);
                if (last) begin
                    pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (desc_valid) begin
            addr     <= desc.src_addr;
            sn       <= desc_sn;
            opcode   <= desc.opcode;
            acc_type <= desc.acc_type;
            ve_info  <= desc.ve_info;
        end else if (rd_cmd_wr) begin
            // step one chunk, offset inside the page stays
            addr <= {addr[63:`TX_BD_CHUNK_SHIFT] + 1'b1, addr[`TX_BD_CHUNK_SHIFT-1:0]};
        end
    end

    // --------------------
    // command word
    always_comb begin
        cmd          = '0;
        cmd.sod      = first;
        cmd.eod      = last;
        cmd.rd_len   = cur_len;
        cmd.opcode   = opcode;
        cmd.sn       = sn;
        cmd.acc_type = acc_type;
        cmd.ve_info  = ve_info;
        cmd.src_addr = addr;
    end

    assign rd_cmd_wdata = tx_bd_pkg::bswap_128x2(cmd);

endmodule

// File: logic/bd_fetch.sv
// pops one descriptor at a time from a show-ahead queue
// data is taken in the same cycle as the pop strobe
`timescale 1ns/1ps
`include "tx_bd_macros.svh"

module bd_fetch (
    input  logic                      clk_sys,
    input  logic                      rst,
    output logic                      bd_fifo_rd,
    input  logic [`TX_BD_QWORD_W-1:0] bd_fifo_rdata,
    input  logic                      bd_fifo_empty,
    input  logic                      rd_cmd_full,
    input  logic                      rsp_afull,
    input  logic                      rsp_pop,
    input  logic                      cmd_done,
    output logic                      desc_valid,
    output tx_bd_pkg::bd_desc_t       desc,
    output logic [`TX_BD_SN_W-1:0]    desc_sn
);

    logic                    busy;
    logic [`TX_BD_SN_W-1:0]  online_cnt;
    logic                    pop_en;
    logic [`TX_BD_CMD_W-1:0] bd_word;

    // low part arrives half-wise byte swapped, top 32 bits carry nothing we need
    assign bd_word = tx_bd_pkg::bswap_128x2(bd_fifo_rdata[`TX_BD_CMD_W-1:0]);

    assign pop_en = !bd_fifo_empty && !busy && !bd_fifo_rd && !rd_cmd_full && !rsp_afull
                    && (online_cnt < `TX_BD_ONLINE_MAX);

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            bd_fifo_rd <= 1'b0;
            desc_valid <= 1'b0;
        end else begin
            bd_fifo_rd <= pop_en;
            desc_valid <= bd_fifo_rd;
        end
    end

    // held from pop until the eod command
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (bd_fifo_rd) begin
            busy <= 1'b1;
        end else if (cmd_done) begin
            busy <= 1'b0;
        end
    end

    // descriptors still waiting for a response
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            online_cnt <= '0;
        end else if (bd_fifo_rd && !rsp_pop) begin
            online_cnt <= online_cnt + 1'b1;
        end else if (!bd_fifo_rd && rsp_pop && online_cnt != '0) begin
            online_cnt <= online_cnt - 1'b1;
        end
    end

    // starts at all ones so the first descriptor gets sn 0
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            desc_sn <= '1;
        end else if (bd_fifo_rd) begin
            desc_sn <= desc_sn + 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (bd_fifo_rd) begin
            desc.thread_id <= bd_word[233:226];
            desc.opcode    <= tx_bd_pkg::bd_op_e'(bd_word[225:224]);
            desc.acc_type  <= bd_word[215:208];
            desc.ve_info   <= bd_word[207:160];
            desc.len       <= bd_word[159:128];
            desc.des_addr  <= bd_word[127:64];
            desc.src_addr  <= bd_word[63:0];
        end
    end

endmodule

// File: logic/tx_bd_pkg.sv
// descriptor, command and output types plus byte order helpers
// the command word is built from 146 bits of fields
`include "tx_bd_macros.svh"

package tx_bd_pkg;

    typedef enum logic [1:0] {
        op_proc     = 2'd0,
        op_read     = 2'd1,
        op_write    = 2'd2,
        op_proc_alt = 2'd3
    } bd_op_e;

    typedef struct packed {
        logic [7:0]  thread_id;
        bd_op_e      opcode;
        logic [7:0]  acc_type;
        logic [47:0] ve_info;
        logic [31:0] len;
        logic [63:0] des_addr;
        logic [63:0] src_addr;
    } bd_desc_t;

    typedef struct packed {
        logic [`TX_BD_CMD_W-147:0]   pad;
        logic                        sod;
        logic                        eod;
        logic [`TX_BD_CHUNK_SHIFT:0] rd_len;
        bd_op_e                      opcode;
        logic [`TX_BD_SN_W-1:0]      sn;
        logic [7:0]                  acc_type;
        logic [47:0]                 ve_info;
        logic [63:0]                 src_addr;
    } rd_cmd_t;

    typedef struct packed {
        logic [`TX_BD_OUT_W-$bits(bd_desc_t)-1:0] pad;
        bd_desc_t                                 desc;
    } bd_out_t;

    // each 128-bit half reversed on its own
    function automatic logic [`TX_BD_CMD_W-1:0] bswap_128x2(input logic [`TX_BD_CMD_W-1:0] d);
        logic [`TX_BD_CMD_W-1:0] q;
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < 16; i++) begin
                q[128*h + 8*i +: 8] = d[128*h + 8*(15-i) +: 8];
            end
        end
        return q;
    endfunction

    function automatic logic [`TX_BD_OUT_W-1:0] bswap_512(input logic [`TX_BD_OUT_W-1:0] d);
        logic [`TX_BD_OUT_W-1:0] q;
        for (int i = 0; i < `TX_BD_OUT_W/8; i++) begin
            q[8*i +: 8] = d[`TX_BD_OUT_W - 8 - 8*i +: 8];
        end
        return q;
    endfunction

endpackage

// File: logic/tx_bd_macros.svh
// widths, depths and thresholds of the tx bd engine
// depth must equal 2**TX_BD_SN_W because the sn wraps freely
`ifndef TX_BD_MACROS_SVH
`define TX_BD_MACROS_SVH

// --------------------
// bus widths
`define TX_BD_QWORD_W       288
`define TX_BD_CMD_W         256
`define TX_BD_OUT_W         512
`define TX_BD_SN_W          9

// --------------------
// storage
`define TX_BD_DEPTH         512

// --------------------
// command split and admission
`define TX_BD_CHUNK_BYTES   4096
`define TX_BD_CHUNK_SHIFT   12
`define TX_BD_ONLINE_MAX    450
`define TX_BD_RSP_AFULL     450

`endif
